// ==== src/mips_alu_defines.svh ====
`ifndef MIPS_ALU_DEFINES_SVH
`define MIPS_ALU_DEFINES_SVH

`define ALU_XLEN      32
`define ALU_RADDR_W   5
`define WB_ADR_W      6

// word addresses 0 to 31 map onto the register file.
`define WB_ADR_INST   6'd32
`define WB_ADR_STATUS 6'd33

`define OP_SPECIAL    6'b000000
`define OP_ADDI       6'b001000
`define OP_ADDIU      6'b001001
`define OP_SLTI       6'b001010
`define OP_SLTIU      6'b001011
`define OP_ANDI       6'b001100
`define OP_ORI        6'b001101
`define OP_XORI       6'b001110
`define OP_LUI        6'b001111

`define FN_SLL        6'b000000
`define FN_SRL        6'b000010
`define FN_SRA        6'b000011
`define FN_SLLV       6'b000100
`define FN_SRLV       6'b000110
`define FN_SRAV       6'b000111
`define FN_ADD        6'b100000
`define FN_ADDU       6'b100001
`define FN_SUB        6'b100010
`define FN_SUBU       6'b100011
`define FN_AND        6'b100100
`define FN_OR         6'b100101
`define FN_XOR        6'b100110
`define FN_NOR        6'b100111
`define FN_SLT        6'b101010
`define FN_SLTU       6'b101011

`define STAT_OVF      0
`define STAT_RI       1

`endif

// ==== src/mips_alu_pkg.sv ====
`include "mips_alu_defines.svh"

package mips_alu_pkg;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`ALU_RADDR_W-1:0] rs;
        logic [`ALU_RADDR_W-1:0] rt;
        logic [`ALU_RADDR_W-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`ALU_RADDR_W-1:0] rs;
        logic [`ALU_RADDR_W-1:0] rt;
        logic [15:0]             imm16;
    } i_fields_t;

    // the same word seen as register-format or immediate-format.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic [`ALU_RADDR_W-1:0] rs;
        logic [`ALU_RADDR_W-1:0] rt;
        logic [`ALU_RADDR_W-1:0] wr_addr;
        logic                    wr_en;
        logic                    use_imm;
        logic [`ALU_XLEN-1:0]    imm;
        logic                    shift_by_reg;
        logic [4:0]              shamt;
        logic                    ovf_check;
        logic                    ri;
    } dec_rec_t;

    typedef struct packed {
        logic                    valid;
        logic                    wr_en;
        logic [`ALU_RADDR_W-1:0] wr_addr;
        logic [`ALU_XLEN-1:0]    result;
        logic                    ovf;
        logic                    ri;
    } exe_rec_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;
        logic [`ALU_XLEN-1:0] dat_w;
    } wb_req_t;

endpackage

// ==== src/inst_decode.sv ====
`timescale 1ns/1ns
`include "mips_alu_defines.svh"

module inst_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  mips_alu_pkg::inst_word_u inst,
    output mips_alu_pkg::dec_rec_t  dec
);

    mips_alu_pkg::dec_rec_t nxt;
    logic                   kept;
    logic                   shamt_zero;
    logic                   rs_zero;

    assign shamt_zero = (inst.r.shamt == 5'd0);
    assign rs_zero    = (inst.r.rs == '0);

    always_comb begin
        nxt              = '0;
        nxt.valid        = 1'b1;
        nxt.rs           = inst.r.rs;
        nxt.rt           = inst.r.rt;
        nxt.shamt        = inst.r.shamt;
        nxt.wr_addr      = inst.i.rt;
        nxt.use_imm      = 1'b1;
        nxt.imm          = {{16{inst.i.imm16[15]}}, inst.i.imm16};
        kept             = shamt_zero;
        case (inst.i.opcode)
            `OP_SPECIAL: begin
                nxt.wr_addr = inst.r.rd;
                nxt.use_imm = 1'b0;
                case (inst.r.funct)
                    `FN_SLL: begin
                        nxt.op = mips_alu_pkg::alu_sll;
                        kept   = rs_zero;
                    end
                    `FN_SRL: begin
                        nxt.op = mips_alu_pkg::alu_srl;
                        kept   = rs_zero;
                    end
                    `FN_SRA: begin
                        nxt.op = mips_alu_pkg::alu_sra;
                        kept   = rs_zero;
                    end
                    `FN_SLLV: begin
                        nxt.op           = mips_alu_pkg::alu_sll;
                        nxt.shift_by_reg = 1'b1;
                    end
                    `FN_SRLV: begin
                        nxt.op           = mips_alu_pkg::alu_srl;
                        nxt.shift_by_reg = 1'b1;
                    end
                    `FN_SRAV: begin
                        nxt.op           = mips_alu_pkg::alu_sra;
                        nxt.shift_by_reg = 1'b1;
                    end
                    `FN_ADD: begin
                        nxt.op        = mips_alu_pkg::alu_add;
                        nxt.ovf_check = 1'b1;
                    end
                    `FN_ADDU: nxt.op = mips_alu_pkg::alu_add;
                    `FN_SUB: begin
                        nxt.op        = mips_alu_pkg::alu_sub;
                        nxt.ovf_check = 1'b1;
                    end
                    `FN_SUBU: nxt.op = mips_alu_pkg::alu_sub;
                    `FN_AND:  nxt.op = mips_alu_pkg::alu_and;
                    `FN_OR:   nxt.op = mips_alu_pkg::alu_or;
                    `FN_XOR:  nxt.op = mips_alu_pkg::alu_xor;
                    `FN_NOR:  nxt.op = mips_alu_pkg::alu_nor;
                    `FN_SLT:  nxt.op = mips_alu_pkg::alu_slt;
                    `FN_SLTU: nxt.op = mips_alu_pkg::alu_sltu;
                    default:  kept   = 1'b0;
                endcase
            end
            `OP_ADDI: begin
                nxt.op        = mips_alu_pkg::alu_add;
                nxt.ovf_check = 1'b1;
                kept          = 1'b1;
            end
            `OP_ADDIU: begin
                nxt.op = mips_alu_pkg::alu_add;
                kept   = 1'b1;
            end
            // sltiu compares against the sign-extended immediate as unsigned.
            `OP_SLTI, `OP_SLTIU: begin
                nxt.op = (inst.i.opcode == `OP_SLTI) ? mips_alu_pkg::alu_slt
                                                     : mips_alu_pkg::alu_sltu;
                kept   = 1'b1;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                nxt.imm = {16'd0, inst.i.imm16};
                nxt.op  = (inst.i.opcode == `OP_ANDI) ? mips_alu_pkg::alu_and :
                          (inst.i.opcode == `OP_ORI)  ? mips_alu_pkg::alu_or
                                                      : mips_alu_pkg::alu_xor;
                kept    = 1'b1;
            end
            `OP_LUI: begin
                nxt.imm = {16'd0, inst.i.imm16};
                nxt.op  = mips_alu_pkg::alu_lui;
                kept    = rs_zero;
            end
            default: kept = 1'b0;
        endcase
        nxt.wr_en = kept;
        nxt.ri    = ~kept;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= '0;
        end else if (issue) begin
            dec <= nxt;
        end else begin
            dec.valid <= 1'b0;
        end
    end

endmodule

// ==== src/alu_execute.sv ====
`timescale 1ns/1ns
`include "mips_alu_defines.svh"

module alu_execute (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_alu_pkg::dec_rec_t      dec,
    output logic [`ALU_RADDR_W-1:0]     rs_addr,
    output logic [`ALU_RADDR_W-1:0]     rt_addr,
    input  logic [`ALU_XLEN-1:0]        rs_data,
    input  logic [`ALU_XLEN-1:0]        rt_data,
    output mips_alu_pkg::exe_rec_t      exe
);

    logic [`ALU_XLEN-1:0] op_a;
    logic [`ALU_XLEN-1:0] op_b;
    logic [`ALU_XLEN-1:0] sum;
    logic [`ALU_XLEN-1:0] diff;
    logic [`ALU_XLEN-1:0] result;
    logic [4:0]           sh;
    logic                 lt_s;
    logic                 lt_u;
    logic                 add_ovf;
    logic                 sub_ovf;
    logic                 ovf;

    assign rs_addr = dec.rs;
    assign rt_addr = dec.rt;

    assign op_a = rs_data;
    assign op_b = dec.use_imm ? dec.imm : rt_data;
    // variable shifts take only the low five bits of rs.
    assign sh   = dec.shift_by_reg ? rs_data[4:0] : dec.shamt;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;
    assign lt_s = ($signed(op_a) < $signed(op_b));
    assign lt_u = (op_a < op_b);

    // add overflows on like operand signs and sub on unlike signs when the result sign flips.
    assign add_ovf = (op_a[`ALU_XLEN-1] == op_b[`ALU_XLEN-1]) &&
                     (sum[`ALU_XLEN-1] != op_a[`ALU_XLEN-1]);
    assign sub_ovf = (op_a[`ALU_XLEN-1] != op_b[`ALU_XLEN-1]) &&
                     (diff[`ALU_XLEN-1] != op_a[`ALU_XLEN-1]);
    assign ovf     = dec.ovf_check &&
                     ((dec.op == mips_alu_pkg::alu_sub) ? sub_ovf : add_ovf);

    always_comb begin
        case (dec.op)
            mips_alu_pkg::alu_add:  result = sum;
            mips_alu_pkg::alu_sub:  result = diff;
            mips_alu_pkg::alu_slt:  result = {{(`ALU_XLEN-1){1'b0}}, lt_s};
            mips_alu_pkg::alu_sltu: result = {{(`ALU_XLEN-1){1'b0}}, lt_u};
            mips_alu_pkg::alu_sll:  result = rt_data << sh;
            mips_alu_pkg::alu_srl:  result = rt_data >> sh;
            mips_alu_pkg::alu_sra:  result = $signed(rt_data) >>> sh;
            mips_alu_pkg::alu_and:  result = op_a & op_b;
            mips_alu_pkg::alu_or:   result = op_a | op_b;
            mips_alu_pkg::alu_xor:  result = op_a ^ op_b;
            mips_alu_pkg::alu_nor:  result = ~(op_a | op_b);
            mips_alu_pkg::alu_lui:  result = {dec.imm[15:0], 16'd0};
            default:                result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe <= '0;
        end else begin
            exe.valid   <= dec.valid;
            exe.wr_en   <= dec.wr_en & ~ovf & ~dec.ri;
            exe.wr_addr <= dec.wr_addr;
            exe.result  <= result;
            exe.ovf     <= ovf;
            exe.ri      <= dec.ri;
        end
    end

endmodule

// ==== src/result_writeback.sv ====
`timescale 1ns/1ns
`include "mips_alu_defines.svh"

module result_writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_alu_pkg::exe_rec_t  exe,
    input  logic [`ALU_RADDR_W-1:0] rs_addr,
    input  logic [`ALU_RADDR_W-1:0] rt_addr,
    output logic [`ALU_XLEN-1:0]    rs_data,
    output logic [`ALU_XLEN-1:0]    rt_data,
    input  logic                    bus_we,
    input  logic [`WB_ADR_W-1:0]    bus_adr,
    input  logic [`ALU_XLEN-1:0]    bus_wdata,
    input  logic                    bus_sel,
    output logic [`ALU_XLEN-1:0]    bus_rdata,
    output logic                    busy
);

    logic [`ALU_XLEN-1:0] regs [1:31];
    logic [1:0]           status;
    logic                 bus_is_reg;
    logic                 bus_is_status;
    logic [`ALU_RADDR_W-1:0] bus_ridx;

    assign bus_ridx      = bus_adr[`ALU_RADDR_W-1:0];
    assign bus_is_reg    = ~bus_adr[`WB_ADR_W-1];
    assign bus_is_status = (bus_adr == `WB_ADR_STATUS);

    // register 0 is hardwired to zero.
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_comb begin
        if (bus_is_status) begin
            bus_rdata = {{(`ALU_XLEN-2){1'b0}}, status};
        end else if (bus_is_reg && bus_ridx != '0) begin
            bus_rdata = regs[bus_ridx];
        end else begin
            bus_rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exe.valid && exe.wr_en && exe.wr_addr != '0) begin
            regs[exe.wr_addr] <= exe.result;
        end else if (bus_sel && bus_we && bus_is_reg && bus_ridx != '0) begin
            regs[bus_ridx] <= bus_wdata;
        end
    end

    // flags are sticky until the status word is written.
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (bus_sel && bus_we && bus_is_status) begin
            status <= '0;
        end else if (exe.valid) begin
            status[`STAT_OVF] <= status[`STAT_OVF] | exe.ovf;
            status[`STAT_RI]  <= status[`STAT_RI] | exe.ri;
        end
    end

    assign busy = exe.valid;

endmodule

// ==== src/mips_alu_core.sv ====
`timescale 1ns/1ns
`include "mips_alu_defines.svh"

module mips_alu_core (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_alu_pkg::wb_req_t wb_req,
    output logic [`ALU_XLEN-1:0]  wb_dat_r,
    output logic                  wb_ack
);

    mips_alu_pkg::inst_word_u inst_word;
    mips_alu_pkg::dec_rec_t   dec;
    mips_alu_pkg::exe_rec_t   exe;

    logic [`ALU_RADDR_W-1:0] rs_addr;
    logic [`ALU_RADDR_W-1:0] rt_addr;
    logic [`ALU_XLEN-1:0]    rs_data;
    logic [`ALU_XLEN-1:0]    rt_data;
    logic [`ALU_XLEN-1:0]    bus_rdata;
    logic                    busy;
    logic                    is_inst;
    logic                    stall;
    logic                    accept;
    logic                    issue;
    logic                    bus_sel;

    assign inst_word = wb_req.dat_w;

    // instructions go straight in; other accesses wait for the pipeline to drain.
    assign is_inst = wb_req.we && (wb_req.adr == `WB_ADR_INST);
    assign stall   = dec.valid | busy;
    assign accept  = wb_req.cyc & wb_req.stb & ~wb_ack & (is_inst | ~stall);
    assign issue   = accept & is_inst;
    assign bus_sel = accept & ~is_inst;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !wb_req.we) begin
            wb_dat_r <= bus_rdata;
        end
    end

    inst_decode decode_i (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .inst  (inst_word),
        .dec   (dec)
    );

    alu_execute execute_i (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .exe     (exe)
    );

    result_writeback writeback_i (
        .clk       (clk),
        .reset     (reset),
        .exe       (exe),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .bus_we    (wb_req.we),
        .bus_adr   (wb_req.adr),
        .bus_wdata (wb_req.dat_w),
        .bus_sel   (bus_sel),
        .bus_rdata (bus_rdata),
        .busy      (busy)
    );

endmodule

// ==== tests/mips_alu_core_props.sv ====
`timescale 1ns/1ns

module mips_alu_core_props (
    input logic                  clk,
    input logic                  reset,
    input mips_alu_pkg::wb_req_t wb_req,
    input logic                  wb_ack
);

    // ack only completes a request that is still presented.
    ack_with_request: assert property (
        @(posedge clk) disable iff (reset) wb_ack |-> (wb_req.cyc && wb_req.stb)
    ) else $error("wb_ack high without cyc and stb");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
    ) else $error("wb_ack high for two cycles in a row");

    ack_low_after_reset: assert property (
        @(posedge clk) reset |=> !wb_ack
    ) else $error("wb_ack high in the cycle after reset");

endmodule

bind mips_alu_core mips_alu_core_props props_i (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_ack (wb_ack)
);

// ==== tests/tb_mips_alu_core.sv ====
`timescale 1ns/1ns
`include "mips_alu_defines.svh"

module tb_mips_alu_core;

    // exp_res holds {ri, ovf, value} from the reference model.
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [33:0] exp_res;
    } vec_t;

    localparam logic [12:0][5:0] r_fns = {`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
        `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLLV, `FN_SRLV, `FN_SRAV};
    localparam logic [2:0][5:0]  sh_fns = {`FN_SLL, `FN_SRL, `FN_SRA};
    localparam logic [6:0][5:0]  i_ops  = {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
        `OP_ANDI, `OP_ORI, `OP_XORI};

    logic                  clk = 1'b0;
    logic                  reset;
    mips_alu_pkg::wb_req_t wb_req;
    logic [31:0]           wb_dat_r;
    logic                  wb_ack;
    vec_t                  table_q[$];
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_passed = 0;

    mips_alu_core dut_i (
        .clk      (clk),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {`OP_SPECIAL, rs, 5'd2, 5'd3, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [15:0] imm);
        return {op, rs, 5'd2, imm};
    endfunction

    // MIPS reference behavior for the kept subset; a is rs data, b is rt data.
    function automatic logic [33:0] ref_result(input logic [31:0] inst, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic        rs_nz;
        logic [31:0] se;
        logic [31:0] ze;
        logic [32:0] wide;
        logic [31:0] r;
        logic        ri;
        logic        ovf;
        op    = inst[31:26];
        fn    = inst[5:0];
        sa    = inst[10:6];
        rs_nz = (inst[25:21] != 5'd0);
        se    = {{16{inst[15]}}, inst[15:0]};
        ze    = {16'd0, inst[15:0]};
        r     = '0;
        wide  = '0;
        ovf   = 1'b0;
        ri    = 1'b0;
        if (op == `OP_SPECIAL) begin
            // immediate shifts need rs zero and all other functions need shamt zero.
            if (fn == `FN_SLL || fn == `FN_SRL || fn == `FN_SRA) begin
                ri = rs_nz;
            end else begin
                ri = (sa != 5'd0);
            end
            case (fn)
                `FN_SLL:  r = b << sa;
                `FN_SRL:  r = b >> sa;
                `FN_SRA:  r = $signed(b) >>> sa;
                `FN_SLLV: r = b << a[4:0];
                `FN_SRLV: r = b >> a[4:0];
                `FN_SRAV: r = $signed(b) >>> a[4:0];
                `FN_ADD, `FN_ADDU: begin
                    wide = {a[31], a} + {b[31], b};
                    r    = wide[31:0];
                    ovf  = (fn == `FN_ADD) && (wide[32] != wide[31]);
                end
                `FN_SUB, `FN_SUBU: begin
                    wide = {a[31], a} - {b[31], b};
                    r    = wide[31:0];
                    ovf  = (fn == `FN_SUB) && (wide[32] != wide[31]);
                end
                `FN_AND:  r = a & b;
                `FN_OR:   r = a | b;
                `FN_XOR:  r = a ^ b;
                `FN_NOR:  r = ~(a | b);
                `FN_SLT:  r = {31'd0, $signed(a) < $signed(b)};
                `FN_SLTU: r = {31'd0, a < b};
                default:  ri = 1'b1;
            endcase
        end else begin
            case (op)
                `OP_ADDI, `OP_ADDIU: begin
                    wide = {a[31], a} + {se[31], se};
                    r    = wide[31:0];
                    ovf  = (op == `OP_ADDI) && (wide[32] != wide[31]);
                end
                `OP_SLTI:  r = {31'd0, $signed(a) < $signed(se)};
                `OP_SLTIU: r = {31'd0, a < se};
                `OP_ANDI:  r = a & ze;
                `OP_ORI:   r = a | ze;
                `OP_XORI:  r = a ^ ze;
                `OP_LUI: begin
                    r  = {inst[15:0], 16'd0};
                    ri = rs_nz;
                end
                default:   ri = 1'b1;
            endcase
        end
        return {ri, ovf, r};
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            tests_passed++;
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        waited       = 0;
        rdata        = '0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 100);
        if (!wb_ack) begin
            $display("bus access to address %0d was not acknowledged within 100 cycles", adr);
            errors++;
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            rdata = wb_dat_r;
            // keep the request up through the ack cycle.
            @(negedge clk);
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
        end
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [5:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    function automatic void add_vector(input logic [31:0] inst, input logic [31:0] a,
                                       input logic [31:0] b);
        vec_t v;
        v.inst    = inst;
        v.a       = a;
        v.b       = b;
        v.exp_res = ref_result(inst, a, b);
        table_q.push_back(v);
    endfunction

    task automatic build_table();
        for (int k = 0; k < 13; k++) begin
            add_vector(r_word(5'd1, 5'd0, r_fns[k]), $urandom, $urandom);
        end
        for (int k = 0; k < 3; k++) begin
            add_vector(r_word(5'd0, 5'($urandom), sh_fns[k]), $urandom, $urandom);
        end
        for (int k = 0; k < 7; k++) begin
            add_vector(i_word(i_ops[k], 5'd1, 16'($urandom)), $urandom, $urandom);
        end
        add_vector(i_word(`OP_LUI, 5'd0, 16'($urandom)), $urandom, $urandom);
        // ADDU wraps on the same operands that make ADD overflow.
        add_vector(r_word(5'd1, 5'd0, `FN_ADD), 32'h7fff_ffff, 32'h0000_0001);
        add_vector(r_word(5'd1, 5'd0, `FN_ADDU), 32'h7fff_ffff, 32'h0000_0001);
        add_vector(i_word(`OP_ADDI, 5'd1, 16'h0001), 32'h7fff_ffff, $urandom);
        add_vector(r_word(5'd1, 5'd0, `FN_SUB), 32'h8000_0000, 32'h0000_0001);
        // LW, BEQ, MFHI and an SLL with rs set.
        add_vector(i_word(6'b100011, 5'd1, 16'h0010), $urandom, $urandom);
        add_vector(i_word(6'b000100, 5'd1, 16'h0004), $urandom, $urandom);
        add_vector(r_word(5'd0, 5'd0, 6'b010000), $urandom, $urandom);
        add_vector(r_word(5'd1, 5'd4, `FN_SLL), $urandom, $urandom);
    endtask

    task automatic apply_vector(input int idx, input vec_t v);
        logic [31:0] exp_r [0:3];
        logic [31:0] exp_stat;
        logic [31:0] got;
        logic [4:0]  dest;
        int          mark;
        mark     = errors;
        exp_r[0] = '0;
        exp_r[1] = v.a;
        exp_r[2] = v.b;
        exp_r[3] = 32'h5eed_0000 + idx;
        // register 0 takes a nonzero write and must still read zero.
        bus_write(6'd0, ~v.b);
        for (int r = 1; r < 4; r++) begin
            bus_write(6'(r), exp_r[r]);
        end
        bus_write(`WB_ADR_STATUS, 32'd0);
        bus_write(`WB_ADR_INST, v.inst);
        dest = (v.inst[31:26] == `OP_SPECIAL) ? v.inst[15:11] : v.inst[20:16];
        if (v.exp_res[33:32] == 2'b00) begin
            exp_r[dest[1:0]] = v.exp_res[31:0];
        end
        // the first read follows the issue directly and must see the write.
        for (int r = 0; r < 4; r++) begin
            bus_read(6'(r), got);
            check_eq($sformatf("vector %0d reg %0d", idx, r), got, exp_r[r]);
        end
        exp_stat               = '0;
        exp_stat[`STAT_OVF]    = v.exp_res[32];
        exp_stat[`STAT_RI]     = v.exp_res[33];
        bus_read(`WB_ADR_STATUS, got);
        check_eq($sformatf("vector %0d status", idx), got, exp_stat);
        end_test($sformatf("vector %0d inst %h", idx, v.inst), mark);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [31:0] w_add;
        logic [31:0] w_xor;
        logic [31:0] w_addi;
        logic [33:0] v1;
        logic [33:0] v2;
        logic [33:0] v3;
        int          mark;
        reset  = 1'b1;
        wb_req = '0;
        void'($urandom(12719));
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;

        mark = errors;
        a    = $urandom;
        bus_write(6'd7, a);
        bus_read(6'd7, got);
        check_eq("reg 7 read-back", got, a);
        bus_write(6'd0, 32'hffff_ffff);
        bus_read(6'd0, got);
        check_eq("reg 0 after write", got, 32'd0);
        end_test("register access", mark);

        for (int n = 0; n < table_q.size(); n++) begin
            apply_vector(n, table_q[n]);
        end

        // the chain r3 = r1 + r2; r4 = r3 ^ r1; r5 = r4 + imm issues with no gap.
        mark   = errors;
        a      = $urandom;
        b      = $urandom;
        w_add  = {`OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU};
        w_xor  = {`OP_SPECIAL, 5'd3, 5'd1, 5'd4, 5'd0, `FN_XOR};
        w_addi = {`OP_ADDIU, 5'd4, 5'd5, 16'h8001};
        v1     = ref_result(w_add, a, b);
        v2     = ref_result(w_xor, v1[31:0], a);
        v3     = ref_result(w_addi, v2[31:0], 32'd0);
        bus_write(6'd1, a);
        bus_write(6'd2, b);
        bus_write(`WB_ADR_INST, w_add);
        bus_write(`WB_ADR_INST, w_xor);
        bus_write(`WB_ADR_INST, w_addi);
        bus_read(6'd4, got);
        check_eq("chain reg 4", got, v2[31:0]);
        bus_read(6'd5, got);
        check_eq("chain reg 5", got, v3[31:0]);
        end_test("dependent chain", mark);

        mark = errors;
        bus_write(`WB_ADR_STATUS, 32'd0);
        bus_write(6'd1, 32'h7fff_ffff);
        bus_write(6'd2, 32'h0000_0001);
        bus_write(`WB_ADR_INST, r_word(5'd1, 5'd0, `FN_ADD));
        bus_write(`WB_ADR_INST, i_word(6'b100011, 5'd1, 16'h0000));
        bus_read(`WB_ADR_STATUS, got);
        check_eq("status after ovf and ri", got, 32'd3);
        bus_write(`WB_ADR_STATUS, 32'd0);
        bus_read(`WB_ADR_STATUS, got);
        check_eq("status after clear", got, 32'd0);
        end_test("status flags", mark);

        $display("tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/mips_alu_pkg.sv
src/inst_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/mips_alu_core.sv
tests/mips_alu_core_props.sv
tests/tb_mips_alu_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and report pass or fail.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_mips_alu_core -f list.f -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
